//--- rtl/extin_backend.sv
// External input backend top, register block, capture engine, output FIFO
`timescale 1ns/1ns

module extin_backend #(
  parameter int DATA_W         = 32,
  parameter int CFG_W          = 4,
  parameter int STS_W          = 4,
  parameter int OUT_FIFO_DEPTH = 8
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // Register side
  input  logic [CFG_W-1:0]             cfg_in,
  input  logic [STS_W-1:0]             ext_sts,
  output logic [16+STS_W-1:0]          core_status,
  input  logic                         clear_req,
  output logic                         clear_finish,
  // Instruction stream
  input  logic                         inst_valid,
  input  logic [extin_pkg::INST_W-1:0] inst_data,
  output logic                         inst_ready,
  // External source
  output logic [CFG_W-1:0]             ext_cfg,
  input  logic                         ext_valid,
  input  logic [DATA_W-1:0]            ext_data,
  output logic                         ext_ready,
  // Captured data
  output logic                         out_valid,
  output logic [DATA_W-1:0]            out_data,
  input  logic                         out_ready,
  // Log entries
  output logic                         log_valid,
  output logic [extin_pkg::LOG_W-1:0]  log_data,
  input  logic                         log_ready,
  output logic                         op_finish
);

  logic              fifo_in_valid;
  logic [DATA_W-1:0] fifo_in_data;
  logic              fifo_in_ready;
  logic [STS_W-1:0]  status_sync;
  logic [15:0]       capture_count;

  extin_ctrl_if ctrl (.clk(clk));

  // Counter in the upper half, synchronized status below
  assign core_status = {capture_count, status_sync};

  extin_regs #(
    .CFG_W(CFG_W),
    .STS_W(STS_W)
  ) u_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .cfg_in       (cfg_in),
    .ext_cfg      (ext_cfg),
    .ext_sts      (ext_sts),
    .status_sync  (status_sync),
    .capture_count(capture_count),
    .clear_req    (clear_req),
    .clear_finish (clear_finish),
    .ctrl         (ctrl.regs)
  );

  extin_capture #(
    .DATA_W(DATA_W)
  ) u_capture (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_valid(inst_valid),
    .inst_data (inst_data),
    .inst_ready(inst_ready),
    .ext_valid (ext_valid),
    .ext_data  (ext_data),
    .ext_ready (ext_ready),
    .fifo_valid(fifo_in_valid),
    .fifo_data (fifo_in_data),
    .fifo_ready(fifo_in_ready),
    .log_valid (log_valid),
    .log_data  (log_data),
    .log_ready (log_ready),
    .op_finish (op_finish),
    .ctrl      (ctrl.engine)
  );

  extin_fifo #(
    .DATA_W        (DATA_W),
    .OUT_FIFO_DEPTH(OUT_FIFO_DEPTH)
  ) u_out_fifo (
    .clk      (clk),
    .rst_n    (rst_n),
    .flush    (ctrl.flush),
    .in_valid (fifo_in_valid),
    .in_data  (fifo_in_data),
    .in_ready (fifo_in_ready),
    .out_valid(out_valid),
    .out_data (out_data),
    .out_ready(out_ready)
  );

endmodule

//--- rtl/extin_capture.sv
// Instruction driven capture engine, moves or drops words and writes log
`timescale 1ns/1ns

module extin_capture #(
  parameter int DATA_W = 32
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         inst_valid,
  input  logic [extin_pkg::INST_W-1:0] inst_data,
  output logic                         inst_ready,
  input  logic                         ext_valid,
  input  logic [DATA_W-1:0]            ext_data,
  output logic                         ext_ready,
  output logic                         fifo_valid,
  output logic [DATA_W-1:0]            fifo_data,
  input  logic                         fifo_ready,
  output logic                         log_valid,
  output logic [extin_pkg::LOG_W-1:0]  log_data,
  input  logic                         log_ready,
  output logic                         op_finish,
  extin_ctrl_if.engine                 ctrl
);

  extin_pkg::extin_state_e           state;
  extin_pkg::extin_op_e              op;
  extin_pkg::extin_op_e              op_dec;
  logic [extin_pkg::TAG_W-1:0]       tag;
  logic [extin_pkg::TAG_W-1:0]       tag_dec;
  logic [extin_pkg::CNT_W-1:0]       cnt_dec;
  logic [extin_pkg::CNT_W-1:0]       cnt_total;
  logic [extin_pkg::CNT_W-1:0]       cnt_done;
  logic                              inst_fire;
  logic                              ext_fire;
  logic                              last_word;

  // ****************************************
  // Instruction decode
  // ****************************************
  always_comb begin
    op_dec = extin_pkg::extin_op_e'(inst_data[extin_pkg::OP_LSB +: extin_pkg::OP_W]);
    // Reserved code runs as NOP
    if (op_dec == extin_pkg::OP_RSVD) begin
      op_dec = extin_pkg::OP_NOP;
    end
  end

  assign tag_dec = inst_data[extin_pkg::TAG_LSB +: extin_pkg::TAG_W];
  assign cnt_dec = inst_data[extin_pkg::CNT_LSB +: extin_pkg::CNT_W];

  // Start only once the source has seen a settled config
  assign inst_ready = (state == extin_pkg::IDLE) && !ctrl.hold && !ctrl.cfg_load;
  assign inst_fire  = inst_valid && inst_ready;

  // ****************************************
  // External stream
  // ****************************************
  assign ext_ready = (state == extin_pkg::RUN) &&
                     ((op == extin_pkg::OP_DROP) || fifo_ready);
  assign ext_fire  = ext_valid && ext_ready;
  assign last_word = (cnt_done == cnt_total - 1'b1);

  // Words reach the FIFO only for capture
  assign fifo_valid = (state == extin_pkg::RUN) && (op == extin_pkg::OP_CAPTURE) && ext_valid;
  assign fifo_data  = ext_data;

  // ****************************************
  // Sequencing
  // ****************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= extin_pkg::IDLE;
      op       <= extin_pkg::OP_NOP;
      cnt_done <= '0;
    end else begin
      case (state)
        extin_pkg::IDLE: begin
          if (inst_fire) begin
            op       <= op_dec;
            cnt_done <= '0;
            // Nothing to move, go straight to the log entry
            if ((op_dec == extin_pkg::OP_NOP) || (cnt_dec == '0)) begin
              state <= extin_pkg::LOG;
            end else begin
              state <= extin_pkg::RUN;
            end
          end
        end
        extin_pkg::RUN: begin
          if (ext_fire) begin
            cnt_done <= cnt_done + 1'b1;
            if (last_word) begin
              state <= extin_pkg::LOG;
            end
          end
        end
        extin_pkg::LOG: begin
          if (log_ready) begin
            state <= extin_pkg::IDLE;
          end
        end
        default: state <= extin_pkg::IDLE;
      endcase
    end
  end

  // Tag and word count of the running instruction
  always_ff @(posedge clk) begin
    if (inst_fire) begin
      tag       <= tag_dec;
      cnt_total <= cnt_dec;
    end
  end

  // ****************************************
  // Log and control outputs
  // ****************************************
  assign log_valid = (state == extin_pkg::LOG);
  assign log_data  = {op, tag, cnt_done};
  assign op_finish = log_valid && log_ready;

  assign ctrl.busy      = (state != extin_pkg::IDLE);
  assign ctrl.word_done = ext_fire && (op == extin_pkg::OP_CAPTURE);

endmodule

//--- rtl/extin_ctrl_if.sv
// Control interface between register block and capture engine
`timescale 1ns/1ns

interface extin_ctrl_if (
  input logic clk
);

  // Engine is between instruction accept and log transfer
  logic busy;
  // Clear pending, no new instruction may start
  logic hold;
  // One pulse per captured word
  logic word_done;
  // Empties the output FIFO, one cycle
  logic flush;
  // Config register took a new value last cycle
  logic cfg_load;

  modport regs (
    input  busy,
    input  word_done,
    output hold,
    output flush,
    output cfg_load
  );

  modport engine (
    input  hold,
    input  cfg_load,
    output busy,
    output word_done
  );

endinterface

//--- rtl/extin_fifo.sv
// Synchronous circular FIFO with valid/ready on both sides and flush
`timescale 1ns/1ns

module extin_fifo #(
  parameter int DATA_W         = 32,
  parameter int OUT_FIFO_DEPTH = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              flush,
  input  logic              in_valid,
  input  logic [DATA_W-1:0] in_data,
  output logic              in_ready,
  output logic              out_valid,
  output logic [DATA_W-1:0] out_data,
  input  logic              out_ready
);

  localparam int PTR_W = (OUT_FIFO_DEPTH > 1) ? $clog2(OUT_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(OUT_FIFO_DEPTH + 1);

  logic [DATA_W-1:0] mem [OUT_FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              push;
  logic              pop;

  assign in_ready  = (count != CNT_W'(OUT_FIFO_DEPTH));
  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(OUT_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(OUT_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

//--- rtl/extin_pkg.sv
// Opcode and capture state enums, instruction and log word layout
package extin_pkg;

  // ****************************************
  // Word widths
  // ****************************************
  localparam int INST_W = 16;
  localparam int LOG_W  = 16;

  // Field widths, same in instruction and log words
  localparam int OP_W  = 2;
  localparam int TAG_W = 6;
  localparam int CNT_W = 8;

  // Field positions, bits 15:14 opcode, 13:8 tag, 7:0 count
  localparam int OP_LSB  = 14;
  localparam int TAG_LSB = 8;
  localparam int CNT_LSB = 0;

  // ****************************************
  // Opcodes
  // ****************************************
  typedef enum logic [OP_W-1:0] {
    OP_NOP     = 2'd0,
    OP_CAPTURE = 2'd1,
    OP_DROP    = 2'd2,
    // Reserved, executed and logged as OP_NOP
    OP_RSVD    = 2'd3
  } extin_op_e;

  // Capture engine states
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    RUN  = 2'd1,
    LOG  = 2'd2
  } extin_state_e;

endpackage

//--- rtl/extin_regs.sv
// Config hand-off, status synchronizer, capture counter, clear sequencer
`timescale 1ns/1ns

module extin_regs #(
  parameter int CFG_W = 4,
  parameter int STS_W = 4
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [CFG_W-1:0] cfg_in,
  output logic [CFG_W-1:0] ext_cfg,
  input  logic [STS_W-1:0] ext_sts,
  output logic [STS_W-1:0] status_sync,
  output logic [15:0]      capture_count,
  input  logic             clear_req,
  output logic             clear_finish,
  extin_ctrl_if.regs       ctrl
);

  typedef enum logic [2:0] {
    CLR_IDLE    = 3'd0,
    CLR_WAIT    = 3'd1,
    CLR_FLUSH   = 3'd2,
    CLR_DONE    = 3'd3,
    CLR_RELEASE = 3'd4
  } clr_state_e;

  clr_state_e       clr_state;
  clr_state_e       clr_next;
  logic [STS_W-1:0] sts_meta;

  // ****************************************
  // Configuration and status
  // ****************************************

  // Config follows cfg_in only between instructions
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ext_cfg       <= '0;
      ctrl.cfg_load <= 1'b0;
    end else begin
      ctrl.cfg_load <= !ctrl.busy && (cfg_in != ext_cfg);
      if (!ctrl.busy) begin
        ext_cfg <= cfg_in;
      end
    end
  end

  // Two flop synchronizer for source status
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sts_meta    <= '0;
      status_sync <= '0;
    end else begin
      sts_meta    <= ext_sts;
      status_sync <= sts_meta;
    end
  end

  // Captured word counter, wraps at 16 bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      capture_count <= '0;
    end else if (ctrl.flush) begin
      capture_count <= '0;
    end else if (ctrl.word_done) begin
      capture_count <= capture_count + 16'd1;
    end
  end

  // ****************************************
  // Clear sequencer
  // ****************************************
  always_comb begin
    clr_next = clr_state;
    case (clr_state)
      CLR_IDLE:    if (clear_req) clr_next = CLR_WAIT;
      // Let a running instruction finish first
      CLR_WAIT:    if (!ctrl.busy) clr_next = CLR_FLUSH;
      CLR_FLUSH:   clr_next = CLR_DONE;
      CLR_DONE:    clr_next = CLR_RELEASE;
      // Request is a level, wait for it to drop
      CLR_RELEASE: if (!clear_req) clr_next = CLR_IDLE;
      default:     clr_next = CLR_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clr_state <= CLR_IDLE;
    end else begin
      clr_state <= clr_next;
    end
  end

  assign ctrl.hold    = (clr_state == CLR_WAIT) || (clr_state == CLR_FLUSH) ||
                        (clr_state == CLR_DONE);
  assign ctrl.flush   = (clr_state == CLR_FLUSH);
  assign clear_finish = (clr_state == CLR_DONE);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build the external input backend testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module extin_tb -f sim.f -o extin_sim

# A failed run stops inside the simulator, the output search decides
sim_out=$(./obj_dir/extin_sim || true)
echo "$sim_out"

if grep -qx "Test OK" <<< "$sim_out"; then
  exit 0
fi
exit 1

//--- sim.f
rtl/extin_pkg.sv
rtl/extin_ctrl_if.sv
rtl/extin_fifo.sv
rtl/extin_regs.sv
rtl/extin_capture.sv
rtl/extin_backend.sv
testbench/extin_clkgen.sv
testbench/extin_checker.sv
testbench/extin_tb.sv

//--- testbench/extin_checker.sv
// Concurrent assertions on capture engine states and handshakes
`timescale 1ns/1ns

module extin_checker (
  input logic                        clk,
  input logic                        rst_n,
  input extin_pkg::extin_state_e     state,
  input logic                        ext_ready,
  input logic                        inst_ready,
  input logic                        hold,
  input logic                        log_valid,
  input logic [extin_pkg::LOG_W-1:0] log_data,
  input logic                        log_ready
);

  // Read by the testbench at the end of the run
  int unsigned assert_fails = 0;

  // Source is never asked for words while the engine is idle
  idle_no_ext_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state == extin_pkg::IDLE) |-> !ext_ready)
  else begin
    $error("ext_ready high in IDLE");
    assert_fails++;
  end

  // Log word holds until it is taken
  log_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (log_valid && !log_ready) |=> (log_valid && $stable(log_data)))
  else begin
    $error("log word changed before log_ready");
    assert_fails++;
  end

  // No new instruction while a clear is pending
  hold_no_inst_a: assert property (@(posedge clk) disable iff (!rst_n)
    hold |-> !inst_ready)
  else begin
    $error("inst_ready high while hold");
    assert_fails++;
  end

endmodule

//--- testbench/extin_clkgen.sv
// Free running clock source for the testbench
`timescale 1ns/1ns

module extin_clkgen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

endmodule

//--- testbench/extin_tb.sv
// Testbench top, stimulus, reference model, compare process and timeout
`timescale 1ns/1ns

module extin_tb;

  localparam int DATA_W    = 32;
  localparam int CFG_W     = 4;
  localparam int STS_W     = 4;
  localparam int CAP_N     = 6;
  localparam int CAP_MAX   = 24;
  localparam int DROP_N    = 3;
  localparam int DROP_MAX  = 16;
  localparam int BP_N      = 8;
  localparam int BP_MAX    = 30;
  localparam int CLR_WORDS = 6;
  localparam int TOTAL_WORDS = CAP_N * CAP_MAX + DROP_N * DROP_MAX + BP_N * BP_MAX +
                               CLR_WORDS + 4;
  localparam int TIMEOUT_CYCLES = TOTAL_WORDS * 8 + 2000;

  logic clk, rst_n, clear_req, clear_finish;
  logic [CFG_W-1:0] cfg_in, ext_cfg, cfg_exp;
  logic [STS_W-1:0] ext_sts, sts_d1, sts_d2;
  logic [16+STS_W-1:0] core_status;
  logic inst_valid, inst_ready, ext_valid, ext_ready, out_valid, out_ready;
  logic log_valid, log_ready, op_finish;
  logic [15:0] inst_data, log_data;
  logic [DATA_W-1:0] ext_data, out_data;

  // Expected traffic and model state
  logic [DATA_W-1:0] ext_q[$];
  logic [DATA_W-1:0] out_exp_q[$];
  logic [15:0] log_exp_q[$];
  int unsigned captured_exp = 0, sent_count = 0, finish_count = 0, cycle_count = 0;
  int out_mode = 0;
  bit log_random = 0, ext_gaps = 0, ext_fired = 0, in_prog = 0;

  extin_clkgen #(.PERIOD_NS(40)) clkgen_i (.clk(clk));

  extin_backend #(
    .DATA_W(DATA_W), .CFG_W(CFG_W), .STS_W(STS_W), .OUT_FIFO_DEPTH(8)
  ) dut_i (
    .clk(clk), .rst_n(rst_n), .cfg_in(cfg_in), .ext_sts(ext_sts),
    .core_status(core_status), .clear_req(clear_req), .clear_finish(clear_finish),
    .inst_valid(inst_valid), .inst_data(inst_data), .inst_ready(inst_ready),
    .ext_cfg(ext_cfg), .ext_valid(ext_valid), .ext_data(ext_data), .ext_ready(ext_ready),
    .out_valid(out_valid), .out_data(out_data), .out_ready(out_ready),
    .log_valid(log_valid), .log_data(log_data), .log_ready(log_ready),
    .op_finish(op_finish)
  );

  bind extin_capture extin_checker checker_i (
    .clk(clk), .rst_n(rst_n), .state(state), .ext_ready(ext_ready),
    .inst_ready(inst_ready), .hold(ctrl.hold), .log_valid(log_valid),
    .log_data(log_data), .log_ready(log_ready)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      abort_run($sformatf("mismatch %s expected 0x%0h actual 0x%0h", name, exp, act));
    end
  endtask

  // Expected log word where reserved runs as NOP and a NOP moves no word
  function automatic logic [15:0] ref_log(input logic [15:0] inst);
    logic [1:0] op;
    logic [5:0] tag;
    logic [7:0] cnt;
    op  = inst[extin_pkg::OP_LSB +: extin_pkg::OP_W];
    tag = inst[extin_pkg::TAG_LSB +: extin_pkg::TAG_W];
    cnt = inst[extin_pkg::CNT_LSB +: extin_pkg::CNT_W];
    if (op == extin_pkg::OP_RSVD) op = extin_pkg::OP_NOP;
    if (op == extin_pkg::OP_NOP) cnt = '0;
    return {op, tag, cnt};
  endfunction

  // Queue source words and expectations, then hand the instruction over
  task automatic send_inst(input logic [1:0] op, input int cnt, input bit flushed);
    logic [15:0] inst;
    logic [15:0] exp_log;
    logic [DATA_W-1:0] word;
    inst = {op, 6'($urandom), 8'(cnt)};
    exp_log = ref_log(inst);
    for (int i = 0; i < int'(exp_log[7:0]); i++) begin
      word = $urandom;
      ext_q.push_back(word);
      if (exp_log[15:14] == extin_pkg::OP_CAPTURE) begin
        captured_exp++;
        if (!flushed) out_exp_q.push_back(word);
      end
    end
    log_exp_q.push_back(exp_log);
    sent_count++;
    @(negedge clk);
    inst_valid = 1'b1;
    inst_data  = inst;
    do @(posedge clk); while (!(inst_valid && inst_ready));
    @(negedge clk);
    inst_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (log_exp_q.size() != 0 || out_exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
  endtask

  // ****************************************
  // Input drivers on the falling edge
  // ****************************************
  always @(negedge clk) begin
    if (rst_n) begin
      if (!ext_valid || ext_fired) begin
        ext_fired = 1'b0;
        ext_valid = (ext_q.size() != 0) && (!ext_gaps || $urandom_range(3) != 0);
        if (ext_valid) ext_data = ext_q[0];
      end
      case (out_mode)
        0: out_ready = 1'b1;
        1: out_ready = ($urandom_range(3) != 0);
        default: out_ready = 1'b0;
      endcase
      log_ready = !log_random || ($urandom_range(2) != 0);
      if ($urandom_range(15) == 0) cfg_in = CFG_W'($urandom);
      if ($urandom_range(7) == 0) ext_sts = STS_W'($urandom);
    end
  end

  // ****************************************
  // Compare process on the rising edge
  // ****************************************
  always @(posedge clk) begin
    if (rst_n) begin
      if (ext_valid && ext_ready) begin
        if (ext_q.size() == 0) abort_run("source word taken while none was queued");
        void'(ext_q.pop_front());
        ext_fired = 1'b1;
      end
      if (out_valid && out_ready) begin
        if (out_exp_q.size() == 0) abort_run("output word seen while none was expected");
        check("out_data", out_exp_q.pop_front(), out_data);
      end
      if (log_valid && log_ready) begin
        if (log_exp_q.size() == 0) abort_run("log word seen while none was expected");
        check("log_data", 32'(log_exp_q.pop_front()), 32'(log_data));
      end
      check("op_finish", 32'(log_valid && log_ready), 32'(op_finish));
      if (op_finish) finish_count++;
      // Config is copied one edge late and frozen while an instruction runs
      check("ext_cfg", 32'(cfg_exp), 32'(ext_cfg));
      if (!in_prog) cfg_exp = cfg_in;
      if (inst_valid && inst_ready) in_prog = 1'b1;
      else if (op_finish) in_prog = 1'b0;
      // Status bits arrive two edges late
      check("status", 32'(sts_d2), 32'(core_status[STS_W-1:0]));
      sts_d2 = sts_d1;
      sts_d1 = ext_sts;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > TIMEOUT_CYCLES) abort_run("timeout, the run hung waiting on the DUT");
  end

  initial begin
    void'($urandom(32'h85064e05));
    rst_n      = 1'b0;
    clear_req  = 1'b0;
    cfg_in     = '0;
    ext_sts    = '0;
    inst_valid = 1'b0;
    inst_data  = '0;
    ext_valid  = 1'b0;
    ext_data   = '0;
    out_ready  = 1'b0;
    log_ready  = 1'b0;
    cfg_exp    = '0;
    sts_d1     = '0;
    sts_d2     = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < CAP_N; i++) begin
      send_inst(extin_pkg::OP_CAPTURE, $urandom_range(CAP_MAX, 1), 0);
    end
    wait_drained();
    check("capture count", captured_exp, 32'(core_status[16+STS_W-1:STS_W]));

    // Drop, NOP, reserved and empty instructions
    for (int i = 0; i < DROP_N; i++) begin
      send_inst(extin_pkg::OP_DROP, $urandom_range(DROP_MAX, 1), 0);
    end
    send_inst(extin_pkg::OP_NOP, 5, 0);
    send_inst(extin_pkg::OP_RSVD, 9, 0);
    send_inst(extin_pkg::OP_CAPTURE, 0, 0);
    send_inst(extin_pkg::OP_DROP, 0, 0);
    wait_drained();

    // Random stalls on every stream
    out_mode   = 1;
    log_random = 1;
    ext_gaps   = 1;
    for (int i = 0; i < BP_N; i++) begin
      send_inst(($urandom_range(1) != 0) ? extin_pkg::OP_CAPTURE : extin_pkg::OP_DROP,
                $urandom_range(BP_MAX, 1), 0);
    end
    wait_drained();
    check("capture count", captured_exp, 32'(core_status[16+STS_W-1:STS_W]));
    log_random = 0;

    // Clear while a capture runs so that its words stay in the FIFO and get flushed
    out_mode = 2;
    send_inst(extin_pkg::OP_CAPTURE, CLR_WORDS, 1);
    clear_req = 1'b1;
    do @(posedge clk); while (!clear_finish);
    check("log pending at clear", 0, log_exp_q.size());
    check("out_valid after clear", 0, 32'(out_valid));
    check("count after clear", 0, 32'(core_status[16+STS_W-1:STS_W]));
    @(posedge clk);
    check("clear_finish width", 0, 32'(clear_finish));
    @(negedge clk);
    clear_req    = 1'b0;
    captured_exp = 0;
    out_mode     = 0;

    send_inst(extin_pkg::OP_CAPTURE, 4, 0);
    wait_drained();
    check("capture count", captured_exp, 32'(core_status[16+STS_W-1:STS_W]));
    check("op_finish count", sent_count, finish_count);

    if (dut_i.u_capture.checker_i.assert_fails != 0) begin
      abort_run("an assertion in the capture engine failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule
